/* sources.f */
+incdir+logic
logic/store_pkg.sv
logic/store_agu.sv
logic/store_buffer.sv
logic/data_sram.sv
logic/store_path_top.sv
tests/store_path_properties.sv
tests/store_path_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module store_path_tb -f sources.f -o store_path_sim

# The simulation's own exit status is not trusted; the output decides
output="$(./obj_dir/store_path_sim 2>&1)" || true
echo "$output"

if echo "$output" | grep -q 'All tests passed!'; then
    exit 0
else
    exit 1
fi

/* tests/store_path_tb.sv */
`include "store_macros.svh"

module store_path_tb;
    import store_pkg::*;

    localparam int MAX_ROWS = 96;

    typedef enum logic [2:0] {
        OP_ENQ, OP_COMMIT, OP_DISCARD, OP_STALL, OP_WAIT, OP_DRAIN, OP_FULL, OP_CHECK
    } op_e;

    logic         clk_i;
    logic         rstn_i;
    logic         store_valid_i;
    store_instr_u store_instr_i;
    logic [31:0]  rs1_val_i;
    logic [31:0]  rs2_val_i;
    sb_idx_t      alloc_idx_o;
    logic         full_o;
    logic         commit_i;
    sb_idx_t      commit_idx_i;
    logic         discard_i;
    sb_idx_t      discard_idx_i;
    logic         mem_stall_i;
    logic [31:0]  dbg_addr_i;
    logic [31:0]  dbg_data_o;

    // Stimulus table
    // addr holds rs1 or the debug address
    op_e         t_op   [MAX_ROWS];
    logic [2:0]  t_f3   [MAX_ROWS];
    logic [11:0] t_imm  [MAX_ROWS];
    logic [31:0] t_addr [MAX_ROWS];
    logic [31:0] t_data [MAX_ROWS];
    logic [31:0] t_exp  [MAX_ROWS];
    string       t_name [MAX_ROWS];
    int          n_rows;
    string       grp;

    // Reference memory and the stores it still owes
    logic [31:0] model_mem [`DMEM_WORDS];
    logic [31:0] sb_addr [`SB_DEPTH];
    logic [31:0] sb_data [`SB_DEPTH];
    store_size_e sb_size [`SB_DEPTH];
    sb_idx_t     next_idx;

    int     errors;
    int     checks;
    int     cycles;
    int     cycle_limit;
    integer seed;

    store_path_top DUT (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .store_valid_i (store_valid_i),
        .store_instr_i (store_instr_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .alloc_idx_o   (alloc_idx_o),
        .full_o        (full_o),
        .commit_i      (commit_i),
        .commit_idx_i  (commit_idx_i),
        .discard_i     (discard_i),
        .discard_idx_i (discard_idx_i),
        .mem_stall_i   (mem_stall_i),
        .dbg_addr_i    (dbg_addr_i),
        .dbg_data_o    (dbg_data_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic void add_row(input op_e op, input logic [2:0] f3,
                                    input logic [11:0] imm, input logic [31:0] addr,
                                    input logic [31:0] data, input logic [31:0] exp);
        t_op[n_rows]   = op;
        t_f3[n_rows]   = f3;
        t_imm[n_rows]  = imm;
        t_addr[n_rows] = addr;
        t_data[n_rows] = data;
        t_exp[n_rows]  = exp;
        t_name[n_rows] = grp;
        n_rows++;
    endfunction

    function automatic void ctl(input op_e op, input logic [31:0] val);
        add_row(op, 3'b000, 12'h000, 32'h0, 32'h0, val);
    endfunction

    // Expected alloc index is the next slot modulo the depth
    function automatic sb_idx_t enq(input logic [2:0] f3, input logic [31:0] rs1,
                                    input logic [11:0] imm, input logic [31:0] data);
        sb_idx_t idx;
        idx          = next_idx;
        sb_addr[idx] = rs1 + {{20{imm[11]}}, imm};
        sb_data[idx] = data;
        sb_size[idx] = store_size_e'(f3[1:0]);
        add_row(OP_ENQ, f3, imm, rs1, data, 32'(idx));
        next_idx++;
        return idx;
    endfunction

    // Byte k of rs2 lands in byte lane (offset + k) of the word
    function automatic void land(input sb_idx_t idx);
        int w;
        int lane;
        int nbytes;
        w    = int'(sb_addr[idx] >> 2) % `DMEM_WORDS;
        lane = int'(sb_addr[idx][1:0]);
        case (sb_size[idx])
            SIZE_B:  nbytes = 1;
            SIZE_H:  nbytes = 2;
            default: nbytes = 4;
        endcase
        for (int b = 0; b < nbytes; b++) begin
            model_mem[w][8*(lane+b) +: 8] = sb_data[idx][8*b +: 8];
        end
    endfunction

    function automatic void chk(input logic [31:0] addr);
        add_row(OP_CHECK, 3'b000, 12'h000, addr, 32'h0,
                model_mem[int'(addr >> 2) % `DMEM_WORDS]);
    endfunction

    function automatic void commit_and_drain(input sb_idx_t idx);
        ctl(OP_COMMIT, 32'(idx));
        ctl(OP_DRAIN, 32'h0);
        land(idx);
    endfunction

    task automatic build_table();
        logic [31:0] r_addr;
        logic [31:0] r_data;
        sb_idx_t     a;
        sb_idx_t     b;
        sb_idx_t     c;
        sb_idx_t     d;
        r_addr = $random(seed) & 32'h0000_00fc;
        r_data = $random(seed);
        grp = "sw_random";
        commit_and_drain(enq(3'b010, r_addr, 12'h000, r_data));
        chk(r_addr);

        grp = "lanes";
        commit_and_drain(enq(3'b010, 32'h10, 12'h000, 32'h1122_3344));
        for (int k = 0; k < 4; k++) begin
            commit_and_drain(enq(3'b000, 32'h10, 12'(k), 32'hdead_be00 | 32'(k)));
            chk(32'h10);
        end
        // Negative offsets from the next word
        commit_and_drain(enq(3'b001, 32'h14, 12'hffc, 32'hcafe_5a5a));
        chk(32'h10);
        commit_and_drain(enq(3'b001, 32'h14, 12'hffe, 32'hcafe_a5a5));
        chk(32'h10);

        grp = "discard";
        a = enq(3'b010, 32'h20, 12'h000, 32'hbad0_bad0);
        b = enq(3'b010, 32'h24, 12'h000, 32'h600d_600d);
        ctl(OP_COMMIT, 32'(b));
        ctl(OP_DISCARD, 32'(a));
        ctl(OP_DRAIN, 32'h0);
        land(b);
        chk(32'h20);
        chk(32'h24);

        grp = "reverse_commit";
        a = enq(3'b010, 32'h30, 12'h000, 32'h1111_1111);
        b = enq(3'b010, 32'h30, 12'h000, 32'h2222_2222);
        c = enq(3'b010, 32'h34, 12'h000, 32'h3333_3333);
        ctl(OP_COMMIT, 32'(c));
        ctl(OP_COMMIT, 32'(b));
        ctl(OP_WAIT, 32'd6);
        chk(32'h30);
        chk(32'h34);
        ctl(OP_COMMIT, 32'(a));
        ctl(OP_DRAIN, 32'h0);
        land(a);
        land(b);
        land(c);
        chk(32'h30);
        chk(32'h34);

        grp = "full_stall";
        ctl(OP_STALL, 32'd1);
        a = enq(3'b010, 32'h40, 12'h000, 32'h4444_4444);
        b = enq(3'b000, 32'h40, 12'h001, 32'h0000_00ee);
        c = enq(3'b001, 32'h44, 12'h002, 32'h0000_beef);
        d = enq(3'b010, 32'h48, 12'h000, 32'h8888_8888);
        ctl(OP_FULL, 32'd1);
        ctl(OP_COMMIT, 32'(a));
        ctl(OP_COMMIT, 32'(b));
        ctl(OP_COMMIT, 32'(c));
        ctl(OP_COMMIT, 32'(d));
        ctl(OP_WAIT, 32'd8);
        chk(32'h40);
        chk(32'h44);
        chk(32'h48);
        ctl(OP_STALL, 32'd0);
        ctl(OP_DRAIN, 32'h0);
        land(a);
        land(b);
        land(c);
        land(d);
        chk(32'h40);
        chk(32'h44);
        chk(32'h48);
        ctl(OP_FULL, 32'd0);
    endtask

    initial begin
        clk_i             = 1'b0;
        rstn_i            = 1'b0;
        store_valid_i     = 1'b0;
        store_instr_i.raw = 32'h0;
        rs1_val_i         = 32'h0;
        rs2_val_i         = 32'h0;
        commit_i          = 1'b0;
        commit_idx_i      = '0;
        discard_i         = 1'b0;
        discard_idx_i     = '0;
        mem_stall_i       = 1'b0;
        dbg_addr_i        = 32'h0;
        errors            = 0;
        checks            = 0;
        cycles            = 0;
        n_rows            = 0;
        next_idx          = '0;
        seed              = 32'hf5db_4b59;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            model_mem[i] = 32'h0;
        end
        build_table();
        cycle_limit = n_rows * 8 + 16;

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk_i);
            store_valid_i = 1'b0;
            commit_i      = 1'b0;
            discard_i     = 1'b0;
            case (t_op[r])
                OP_ENQ: begin
                    store_instr_i.raw = {t_imm[r][11:5], 5'd2, 5'd1, t_f3[r],
                                         t_imm[r][4:0], 7'b0100011};
                    rs1_val_i     = t_addr[r];
                    rs2_val_i     = t_data[r];
                    store_valid_i = 1'b1;
                    check_value({t_name[r], " alloc_idx"}, t_exp[r], 32'(alloc_idx_o));
                end
                OP_COMMIT: begin
                    commit_i     = 1'b1;
                    commit_idx_i = sb_idx_t'(t_exp[r]);
                end
                OP_DISCARD: begin
                    discard_i     = 1'b1;
                    discard_idx_i = sb_idx_t'(t_exp[r]);
                end
                OP_STALL: mem_stall_i = t_exp[r][0];
                OP_WAIT:  repeat (t_exp[r]) @(negedge clk_i);
                // Empty buffer means every committed store has landed
                OP_DRAIN: while (DUT.u_store_buffer.valid_q != '0) @(negedge clk_i);
                OP_FULL:  check_value({t_name[r], " full"}, t_exp[r], 32'(full_o));
                default: begin
                    dbg_addr_i = t_addr[r];
                    #1;
                    check_value({t_name[r], " mem word"}, t_exp[r], dbg_data_o);
                end
            endcase
        end
        @(negedge clk_i);
        store_valid_i = 1'b0;
        commit_i      = 1'b0;
        discard_i     = 1'b0;

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* tests/store_path_properties.sv */
`include "store_macros.svh"

module store_path_properties (
    input logic                 clk_i,
    input logic                 rstn_i,
    input logic                 enq_valid_i,
    input logic                 full_i,
    input logic [`SB_DEPTH-1:0] entry_valid_i,
    input logic                 req_valid_i,
    input logic                 req_ready_i,
    input logic [31:0]          addr_i,
    input logic [31:0]          data_i,
    input logic [3:0]           strb_i
);

    // A request rises only for a store already held before the edge
    a_no_req_when_empty : assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(req_valid_i) |-> ($past(full_i) || $past(entry_valid_i) != '0))
        else $error("memory request raised while the store buffer was empty");

    // Request held steady until the SRAM takes it
    a_req_stable : assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_valid_i && !req_ready_i) |=>
        (req_valid_i && $stable(addr_i) && $stable(data_i) && $stable(strb_i)))
        else $error("memory request changed before it was accepted");

    a_no_enq_when_full : assert property (@(posedge clk_i) disable iff (!rstn_i)
        full_i |-> !enq_valid_i)
        else $error("store enqueued while the store buffer is full");

endmodule

bind store_buffer store_path_properties u_properties (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .enq_valid_i   (valid_i),
    .full_i        (full_o),
    .entry_valid_i (valid_q),
    .req_valid_i   (req_valid_o),
    .req_ready_i   (req_ready_i),
    .addr_i        (addr_o),
    .data_i        (data_wr_o),
    .strb_i        (strb_o)
);

/* logic/store_path_top.sv */
module store_path_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  logic                    store_valid_i,
    input  store_pkg::store_instr_u store_instr_i,
    input  logic [31:0]             rs1_val_i,
    input  logic [31:0]             rs2_val_i,
    output store_pkg::sb_idx_t      alloc_idx_o,
    output logic                    full_o,

    input  logic                    commit_i,
    input  store_pkg::sb_idx_t      commit_idx_i,
    input  logic                    discard_i,
    input  store_pkg::sb_idx_t      discard_idx_i,

    input  logic                    mem_stall_i,
    input  logic [31:0]             dbg_addr_i,
    output logic [31:0]             dbg_data_o
);

    logic        agu_valid;
    logic [31:0] agu_addr;
    logic [31:0] agu_data;
    logic [3:0]  agu_strb;

    logic        mem_req_valid;
    logic        mem_req_ready;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_strb;
    logic        mem_rsp_valid;
    logic        mem_rsp_ready;

    store_agu u_agu (
        .store_valid_i (store_valid_i),
        .store_instr_i (store_instr_i),
        .rs1_val_i     (rs1_val_i),
        .rs2_val_i     (rs2_val_i),
        .agu_valid_o   (agu_valid),
        .agu_addr_o    (agu_addr),
        .agu_data_o    (agu_data),
        .agu_strb_o    (agu_strb)
    );

    store_buffer u_store_buffer (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (agu_valid),
        .addr_i        (agu_addr),
        .data_i        (agu_data),
        .strb_i        (agu_strb),
        .alloc_idx_o   (alloc_idx_o),
        .commit_i      (commit_i),
        .commit_idx_i  (commit_idx_i),
        .discard_i     (discard_i),
        .discard_idx_i (discard_idx_i),
        .full_o        (full_o),
        .req_valid_o   (mem_req_valid),
        .req_ready_i   (mem_req_ready),
        .addr_o        (mem_addr),
        .data_wr_o     (mem_wdata),
        .strb_o        (mem_strb),
        .rsp_valid_i   (mem_rsp_valid),
        .rsp_ready_o   (mem_rsp_ready)
    );

    data_sram u_data_sram (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (mem_req_valid),
        .req_ready_o (mem_req_ready),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .strb_i      (mem_strb),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_ready_i (mem_rsp_ready),
        .stall_i     (mem_stall_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_data_o  (dbg_data_o)
    );

endmodule

/* logic/data_sram.sv */
`include "store_macros.svh"

module data_sram (
    input  logic        clk_i,
    input  logic        rstn_i,

    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  strb_i,

    output logic        rsp_valid_o,
    input  logic        rsp_ready_i,

    input  logic        stall_i,

    input  logic [31:0] dbg_addr_i,
    output logic [31:0] dbg_data_o
);
    localparam int WORD_AW = $clog2(`DMEM_WORDS);

    logic [31:0]        mem_q [`DMEM_WORDS];
    logic               pending_q;
    logic               accept;
    logic [WORD_AW-1:0] wr_idx;
    logic [WORD_AW-1:0] dbg_idx;

    // Byte addresses in, word index into the array
    assign wr_idx  = addr_i[WORD_AW+1:2];
    assign dbg_idx = dbg_addr_i[WORD_AW+1:2];

    // One write in flight at a time
    assign req_ready_o = !pending_q && !stall_i;
    assign accept      = req_valid_i && req_ready_o;
    assign rsp_valid_o = pending_q;

    assign dbg_data_o = mem_q[dbg_idx];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (accept) begin
            for (int b = 0; b < 4; b++) begin
                if (strb_i[b]) begin
                    mem_q[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
        end else if (rsp_ready_i) begin
            pending_q <= 1'b0;
        end
    end

endmodule

/* logic/store_buffer.sv */
`include "store_macros.svh"

module store_buffer (
    input  logic               clk_i,
    input  logic               rstn_i,

    input  logic               valid_i,
    input  logic [31:0]        addr_i,
    input  logic [31:0]        data_i,
    input  logic [3:0]         strb_i,
    output store_pkg::sb_idx_t alloc_idx_o,

    input  logic               commit_i,
    input  store_pkg::sb_idx_t commit_idx_i,
    input  logic               discard_i,
    input  store_pkg::sb_idx_t discard_idx_i,
    output logic               full_o,

    output logic               req_valid_o,
    input  logic               req_ready_i,
    output logic [31:0]        addr_o,
    output logic [31:0]        data_wr_o,
    output logic [3:0]         strb_o,

    input  logic               rsp_valid_i,
    output logic               rsp_ready_o
);
    import store_pkg::*;

    logic [31:0] addr_q [`SB_DEPTH];
    logic [31:0] data_q [`SB_DEPTH];
    logic [3:0]  strb_q [`SB_DEPTH];

    logic [`SB_DEPTH-1:0] valid_q, valid_d;
    logic [`SB_DEPTH-1:0] committed_q, committed_d;
    logic [`SB_DEPTH-1:0] discard_q, discard_d;
    logic [`SB_DEPTH-1:0] in_flight_q, in_flight_d;

    sb_idx_t head_q, head_d;
    sb_idx_t tail_q, tail_d;

    logic head_issue;
    logic head_drop;
    logic head_done;

    // Head may go to memory only once, and only if committed and kept
    assign head_issue = valid_q[head_q] && committed_q[head_q] &&
                        !discard_q[head_q] && !in_flight_q[head_q];
    assign head_drop  = valid_q[head_q] && discard_q[head_q] && !in_flight_q[head_q];
    assign head_done  = rsp_valid_i && rsp_ready_o;

    assign req_valid_o = head_issue;
    assign addr_o      = addr_q[head_q];
    assign data_wr_o   = data_q[head_q];
    assign strb_o      = strb_q[head_q];
    assign rsp_ready_o = in_flight_q[head_q];

    assign alloc_idx_o = tail_q;
    assign full_o      = (tail_q == head_q) && valid_q[head_q];

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            addr_q[tail_q] <= addr_i;
            data_q[tail_q] <= data_i;
            strb_q[tail_q] <= strb_i;
        end
    end

    always_comb begin
        valid_d     = valid_q;
        committed_d = committed_q;
        discard_d   = discard_q;
        in_flight_d = in_flight_q;
        head_d      = head_q;
        tail_d      = tail_q;

        if (valid_i) begin
            valid_d[tail_q]     = 1'b1;
            committed_d[tail_q] = 1'b0;
            discard_d[tail_q]   = 1'b0;
            in_flight_d[tail_q] = 1'b0;
            tail_d              = tail_q + 1'b1;
        end

        // ROB marks only entries already held
        if (commit_i && valid_q[commit_idx_i]) begin
            committed_d[commit_idx_i] = 1'b1;
        end
        if (discard_i && valid_q[discard_idx_i]) begin
            discard_d[discard_idx_i] = 1'b1;
        end

        if (head_issue && req_ready_i) begin
            in_flight_d[head_q] = 1'b1;
        end

        // Retire on write response, or drop a discarded head right away
        if (head_done || head_drop) begin
            valid_d[head_q]     = 1'b0;
            in_flight_d[head_q] = 1'b0;
            head_d              = head_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q     <= '0;
            committed_q <= '0;
            discard_q   <= '0;
            in_flight_q <= '0;
            head_q      <= '0;
            tail_q      <= '0;
        end else begin
            valid_q     <= valid_d;
            committed_q <= committed_d;
            discard_q   <= discard_d;
            in_flight_q <= in_flight_d;
            head_q      <= head_d;
            tail_q      <= tail_d;
        end
    end

endmodule

/* logic/store_agu.sv */
module store_agu (
    input  logic                    store_valid_i,
    input  store_pkg::store_instr_u store_instr_i,
    input  logic [31:0]             rs1_val_i,
    input  logic [31:0]             rs2_val_i,
    output logic                    agu_valid_o,
    output logic [31:0]             agu_addr_o,
    output logic [31:0]             agu_data_o,
    output logic [3:0]              agu_strb_o
);
    import store_pkg::*;

    logic [31:0] imm;
    logic [31:0] eff_addr;
    logic [1:0]  lane;
    store_size_e store_size;

    // Split S-type immediate, sign extended
    assign imm = {{20{store_instr_i.fields.imm_hi[6]}},
                  store_instr_i.fields.imm_hi,
                  store_instr_i.fields.imm_lo};

    assign eff_addr = rs1_val_i + imm;
    assign lane     = eff_addr[1:0];

    always_comb begin
        case (store_instr_i.fields.funct3)
            3'b000:  store_size = SIZE_B;
            3'b001:  store_size = SIZE_H;
            default: store_size = SIZE_W;
        endcase
    end

    // Move rs2 up to its byte lane, strobes mark the bytes written
    always_comb begin
        agu_data_o = rs2_val_i << {lane, 3'b000};
        case (store_size)
            SIZE_B:  agu_strb_o = 4'b0001 << lane;
            SIZE_H:  agu_strb_o = 4'b0011 << lane;
            default: agu_strb_o = 4'b1111;
        endcase
    end

    assign agu_valid_o = store_valid_i;
    assign agu_addr_o  = {eff_addr[31:2], 2'b00};

endmodule

/* logic/store_pkg.sv */
`include "store_macros.svh"

package store_pkg;

    // S-type layout, msb first
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // Same store word, raw or decoded
    typedef union packed {
        logic [31:0] raw;
        s_type_t     fields;
    } store_instr_u;

    // Encoding follows funct3[1:0] of SB/SH/SW
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } store_size_e;

    // Store buffer slot, handed to the ROB at enqueue
    typedef logic [`SB_IDX_W-1:0] sb_idx_t;

endpackage

/* logic/store_macros.svh */
`ifndef STORE_MACROS_SVH
`define STORE_MACROS_SVH

// Store buffer entries, power of two
`define SB_DEPTH 4

// Must equal log2 of SB_DEPTH
`define SB_IDX_W 2

// Data SRAM size in 32-bit words
`define DMEM_WORDS 64

`endif
